// File: tb.f
common/xpu_pkg.sv
src/xpu_ctrl_regs.sv
tsf/tsf_timer.sv
tsf/time_slice.sv
src/tx_on_detection.sv
src/xpu_top.sv
tests/tb_xpu.sv

// File: Makefile
# Verilator build and run for the xpu testbench

VERILATOR ?= verilator
TOP       ?= tb_xpu
FLAGS     ?= -Wall
OBJ_DIR   ?= obj_dir

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): tb.f $(shell cat tb.f)
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f tb.f

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f tb.f

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_xpu.sv
// self-checking testbench for xpu_top; stops at the first mismatch and needs no stimulus files
`timescale 1ns/1ns

module tb_xpu import xpu_pkg::*; ();

    localparam int CLK_NS  = 8;
    localparam int TEST_US = 280; // reset 4, load 6, slices 2x121, tx and overrides ~20

    logic clk_i, rst_n_i;
    logic reg_wr_en_i;
    logic [REG_ADDR_W-1:0] reg_addr_i;
    logic [REG_DATA_W-1:0] reg_wdata_i;
    logic phy_tx_started_i, phy_tx_done_i, tx_iq_fifo_empty_i;
    tsf_t tsf_runtime_val_o;
    logic tsf_pulse_1m_o, tx_bb_is_ongoing_o, tx_rf_is_ongoing_o;
    logic mute_adc_o, high_tx_allowed0_o, high_tx_allowed1_o;

    // expected-state model stepped on each rising edge
    logic [31:0] m_reg [32];      // last word written per address
    logic        load_pend;       // load strobe in flight
    tsf_t        base;            // tsf at the last load
    longint      cyc;             // edges since reset or load
    logic        slice_ok;        // slice rule holds since the last load
    logic        bb, done_seen;
    int          rem;             // rf tail cycles left
    logic [31:0] lfsr_q = 32'h34fe;

    xpu_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS/2) clk_i = ~clk_i;
    end

    // galois lfsr stepped once per bit
    function automatic logic [63:0] rnd(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic tsf_t tsf_ref(input tsf_t b, input longint c);
        return b + tsf_t'(c / CLKS_PER_US); // one step per full microsecond
    endfunction

    function automatic logic pulse_ref(input longint c);
        return (c != 0) && (c % CLKS_PER_US == 0);
    endfunction

    // slice count moves on the edge after the pulse
    function automatic logic slice_ref(input longint c, input int tot, input int st, input int en);
        longint m;
        if (tot == 0) return 1'b0;
        m = ((c - 1) / CLKS_PER_US) % tot;
        return (m >= st) && (m < en);
    endfunction

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (m_reg[i]) m_reg[i] = '0;
            {load_pend, bb, done_seen, base, cyc, rem} = '0;
            slice_ok = 1'b1;
        end else begin
            // tsf load lands one edge after the strobe
            if (load_pend) begin
                base = {1'b0, m_reg[ADDR_TSF_HI][30:0], m_reg[ADDR_TSF_LO]};
                cyc = 0;
                slice_ok = 1'b1;
            end else begin
                cyc++;
            end
            load_pend = reg_wr_en_i && reg_addr_i == ADDR_TSF_HI
                     && reg_wdata_i[TSF_LOAD_BIT] && !m_reg[ADDR_TSF_HI][TSF_LOAD_BIT];
            // tx activity with the clear level taken from the old register value
            if (m_reg[ADDR_SOFT_RST][RST_TXDET]) begin
                {bb, done_seen, rem} = '0;
            end else if (bb) begin
                if (phy_tx_done_i) done_seen = 1'b1;
                if (done_seen && tx_iq_fifo_empty_i) begin
                    bb = 1'b0;
                    done_seen = 1'b0;
                    rem = int'(m_reg[ADDR_RF_DELAY][DELAY_W-1:0]);
                end
            end else begin
                if (rem > 0) rem--;
                if (phy_tx_started_i) begin
                    bb = 1'b1;
                    rem = 0;
                end
            end
            if (reg_wr_en_i) begin
                m_reg[reg_addr_i] = reg_wdata_i;
                if (reg_addr_i >= ADDR_SLICE0_TOTAL && reg_addr_i <= ADDR_SLICE1_END)
                    slice_ok = 1'b0; // period realigns only on a load
            end
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error %s: got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_hta(input string name, input logic got, input int s);
        logic [31:0] ovr;
        int          a;
        ovr = m_reg[ADDR_OVERRIDE];
        a = int'((s == 0) ? ADDR_SLICE0_TOTAL : ADDR_SLICE1_TOTAL);
        if (ovr[s ? OVR_HTA1_EN : OVR_HTA0_EN])
            check(name, 64'(got), 64'(ovr[s ? OVR_HTA1_VAL : OVR_HTA0_VAL]));
        else if (slice_ok && cyc >= 1)
            check(name, 64'(got), 64'(slice_ref(cyc, int'(m_reg[a][SLICE_W-1:0]),
                  int'(m_reg[a+1][SLICE_W-1:0]), int'(m_reg[a+2][SLICE_W-1:0]))));
    endtask

    // outputs settle long before the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check("tsf_runtime_val_o", tsf_runtime_val_o, tsf_ref(base, cyc));
            check("tsf_pulse_1m_o", 64'(tsf_pulse_1m_o), 64'(pulse_ref(cyc)));
            check("tx_bb_is_ongoing_o", 64'(tx_bb_is_ongoing_o), 64'(bb));
            check("tx_rf_is_ongoing_o", 64'(tx_rf_is_ongoing_o), 64'(bb || rem > 0));
            check("mute_adc_o", 64'(mute_adc_o), 64'(m_reg[ADDR_OVERRIDE][OVR_MUTE_EN] ?
                  m_reg[ADDR_OVERRIDE][OVR_MUTE_VAL] : (bb || rem > 0)));
            check_hta("high_tx_allowed0_o", high_tx_allowed0_o, 0);
            check_hta("high_tx_allowed1_o", high_tx_allowed1_o, 1);
        end
    end

    task automatic wr(input logic [REG_ADDR_W-1:0] a, input logic [31:0] d);
        @(negedge clk_i);
        reg_wr_en_i = 1'b1;
        reg_addr_i  = a;
        reg_wdata_i = d;
        @(negedge clk_i);
        reg_wr_en_i = 1'b0;
    endtask

    task automatic run_us(input int n);
        repeat (n * CLKS_PER_US) @(negedge clk_i);
    endtask

    task automatic load_tsf(input tsf_t v);
        wr(ADDR_TSF_HI, 32'h0); // arm a fresh 0 -> 1 edge
        wr(ADDR_TSF_LO, v[31:0]);
        wr(ADDR_TSF_HI, {1'b1, v[62:32]});
    endtask

    task automatic slice_cfg(input int s, input int tot);
        int st, en;
        st = (tot == 0) ? 0 : int'(rnd(8)) % tot;
        en = (tot == 0) ? 0 : st + 1 + int'(rnd(8)) % (tot - st);
        wr(REG_ADDR_W'(ADDR_SLICE0_TOTAL + 3*s), tot);
        wr(REG_ADDR_W'(ADDR_SLICE0_START + 3*s), st);
        wr(REG_ADDR_W'(ADDR_SLICE0_END + 3*s), en);
    endtask

    task automatic tx_run(input int gap, input int hold);
        @(negedge clk_i);
        phy_tx_started_i   = 1'b1;
        tx_iq_fifo_empty_i = 1'b0;
        @(negedge clk_i);
        phy_tx_started_i = 1'b0;
        repeat (gap) @(negedge clk_i);
        phy_tx_done_i = 1'b1;
        @(negedge clk_i);
        phy_tx_done_i = 1'b0;
        repeat (hold) @(negedge clk_i);
        tx_iq_fifo_empty_i = 1'b1;
        repeat (80) @(negedge clk_i); // longest tail is 63
    endtask

    initial begin
        {reg_wr_en_i, reg_addr_i, reg_wdata_i} = '0;
        {phy_tx_started_i, phy_tx_done_i} = '0;
        tx_iq_fifo_empty_i = 1'b1;
        rst_n_i = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        run_us(3);                                  // free running from 0
        wr(ADDR_TSF_LO, 32'(rnd(32)));
        wr(ADDR_TSF_HI, {1'b1, 31'(rnd(31))});
        run_us(2);
        wr(ADDR_TSF_HI, {1'b1, 31'(rnd(31))});      // msb still set so no reload
        run_us(2);
        for (int r = 0; r < 2; r++) begin
            slice_cfg(0, 1 + int'(rnd(8)) % 40);
            slice_cfg(1, (r == 1) ? 0 : 1 + int'(rnd(8)) % 40);
            load_tsf('0);
            run_us(3 * 40);
        end
        for (int t = 0; t < 4; t++) begin
            wr(ADDR_RF_DELAY, 32'(rnd(6)));
            tx_run(1 + int'(rnd(4)), int'(rnd(3)));
        end
        wr(ADDR_OVERRIDE, (1 << OVR_MUTE_VAL) | (1 << OVR_MUTE_EN) | (1 << OVR_HTA0_EN)
                          | (1 << OVR_HTA1_EN));
        run_us(1);
        // hta1 forced high so its return to the closed slice 1 shows
        wr(ADDR_OVERRIDE, (1 << OVR_MUTE_EN) | (1 << OVR_HTA0_EN) | (1 << OVR_HTA0_VAL)
                          | (1 << OVR_HTA1_EN) | (1 << OVR_HTA1_VAL));
        run_us(1);
        wr(ADDR_OVERRIDE, 32'h0);
        tx_run(3, 2);                               // mute follows rf again
        @(negedge clk_i);
        phy_tx_started_i = 1'b1;
        @(negedge clk_i);
        phy_tx_started_i = 1'b0;
        repeat (3) @(negedge clk_i);
        wr(ADDR_SOFT_RST, 1 << RST_TXDET);          // kill the tx mid-flight
        repeat (4) @(negedge clk_i);
        wr(ADDR_SOFT_RST, 32'h0);
        run_us(1);
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(64'(2) * TEST_US * CLKS_PER_US * CLK_NS);
        $display("Finished with errors");
        $fatal(1, "timeout, the tests did not finish in time");
    end

endmodule

// File: src/xpu_top.sv
// time base and tx activity part of the lower MAC with a plain write port and no readback
`timescale 1ns/1ns

module xpu_top import xpu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  reg_wr_en_i,
    input  logic [REG_ADDR_W-1:0] reg_addr_i,
    input  logic [REG_DATA_W-1:0] reg_wdata_i,
    input  logic                  phy_tx_started_i,
    input  logic                  phy_tx_done_i,
    input  logic                  tx_iq_fifo_empty_i,
    output tsf_t                  tsf_runtime_val_o,
    output logic                  tsf_pulse_1m_o,
    output logic                  tx_bb_is_ongoing_o,
    output logic                  tx_rf_is_ongoing_o,
    output logic                  mute_adc_o,
    output logic                  high_tx_allowed0_o,
    output logic                  high_tx_allowed1_o
);

    logic               tsf_load, tsf_loaded;
    tsf_t               tsf_load_val;
    slice_cnt_t         slice0_total, slice0_start, slice0_end;
    slice_cnt_t         slice1_total, slice1_start, slice1_end;
    logic [DELAY_W-1:0] rf_delay;
    logic               txdet_clr, slice_clr;
    logic               slice_en0, slice_en1;

    xpu_ctrl_regs regs_i (
        .clk_i, .rst_n_i, .reg_wr_en_i, .reg_addr_i, .reg_wdata_i,
        .slice_en0_i       (slice_en0),
        .slice_en1_i       (slice_en1),
        .tx_rf_is_ongoing_i(tx_rf_is_ongoing_o),
        .tsf_load_o        (tsf_load),
        .tsf_load_val_o    (tsf_load_val),
        .slice0_total_o    (slice0_total),
        .slice0_start_o    (slice0_start),
        .slice0_end_o      (slice0_end),
        .slice1_total_o    (slice1_total),
        .slice1_start_o    (slice1_start),
        .slice1_end_o      (slice1_end),
        .rf_delay_o        (rf_delay),
        .txdet_clr_o       (txdet_clr),
        .slice_clr_o       (slice_clr),
        .mute_adc_o, .high_tx_allowed0_o, .high_tx_allowed1_o
    );

    tsf_timer tsf_timer_i (
        .clk_i, .rst_n_i,
        .tsf_load_i    (tsf_load),
        .tsf_load_val_i(tsf_load_val),
        .tsf_runtime_val_o, .tsf_pulse_1m_o,
        .tsf_loaded_o  (tsf_loaded)
    );

    // slice 0 and slice 1 share the us pulse and the soft clear
    time_slice slice0_i (
        .clk_i, .rst_n_i,
        .clr_i(slice_clr), .tsf_pulse_1m_i(tsf_pulse_1m_o), .tsf_loaded_i(tsf_loaded),
        .count_total_i(slice0_total), .count_start_i(slice0_start), .count_end_i(slice0_end),
        .slice_en_o(slice_en0)
    );

    time_slice slice1_i (
        .clk_i, .rst_n_i,
        .clr_i(slice_clr), .tsf_pulse_1m_i(tsf_pulse_1m_o), .tsf_loaded_i(tsf_loaded),
        .count_total_i(slice1_total), .count_start_i(slice1_start), .count_end_i(slice1_end),
        .slice_en_o(slice_en1)
    );

    tx_on_detection tx_on_detection_i (
        .clk_i, .rst_n_i,
        .clr_i(txdet_clr),
        .phy_tx_started_i, .phy_tx_done_i, .tx_iq_fifo_empty_i,
        .rf_delay_i(rf_delay),
        .tx_bb_is_ongoing_o, .tx_rf_is_ongoing_o
    );

endmodule

// File: src/tx_on_detection.sv
// tracks one transmit at a time; soft clear acts on the edge after it is written
`timescale 1ns/1ns

module tx_on_detection import xpu_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               clr_i,              // soft clear, back to idle
    input  logic               phy_tx_started_i,   // pulse
    input  logic               phy_tx_done_i,      // pulse
    input  logic               tx_iq_fifo_empty_i, // level
    input  logic [DELAY_W-1:0] rf_delay_i,         // rf tail in cycles
    output logic               tx_bb_is_ongoing_o,
    output logic               tx_rf_is_ongoing_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BB,       // phy sending
        ST_DRAIN,    // done seen, iq fifo still has samples
        ST_RF_TAIL   // bb over, rf chain still busy
    } state_t;

    state_t             state_q, state_d;
    state_t             bb_exit;
    logic [DELAY_W-1:0] tail_cnt_q;

    // zero delay skips the tail
    assign bb_exit = (rf_delay_i == '0) ? ST_IDLE : ST_RF_TAIL;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (phy_tx_started_i) state_d = ST_BB;
            end
            ST_BB: begin
                if (phy_tx_done_i) state_d = tx_iq_fifo_empty_i ? bb_exit : ST_DRAIN;
            end
            ST_DRAIN: begin
                if (tx_iq_fifo_empty_i) state_d = bb_exit;
            end
            ST_RF_TAIL: begin
                if (phy_tx_started_i) begin
                    state_d = ST_BB; // back-to-back tx
                end else if (tail_cnt_q <= DELAY_W'(1)) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        if (clr_i) state_d = ST_IDLE;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            tail_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (clr_i) begin
                tail_cnt_q <= '0;
            end else if (state_d == ST_RF_TAIL && state_q != ST_RF_TAIL) begin
                tail_cnt_q <= rf_delay_i;                 // tail starts
            end else if (state_q == ST_RF_TAIL && tail_cnt_q != '0) begin
                tail_cnt_q <= tail_cnt_q - DELAY_W'(1);   // one cycle of tail gone
            end
        end
    end

    assign tx_bb_is_ongoing_o = (state_q == ST_BB) || (state_q == ST_DRAIN);
    assign tx_rf_is_ongoing_o = (state_q != ST_IDLE); // bb plus tail

endmodule

// File: tsf/time_slice.sv
// one repeating slice window in TSF microseconds; total of zero keeps the window closed
`timescale 1ns/1ns

module time_slice import xpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clr_i,          // soft clear level
    input  logic       tsf_pulse_1m_i,
    input  logic       tsf_loaded_i,   // realign period to a new TSF
    input  slice_cnt_t count_total_i,  // period length
    input  slice_cnt_t count_start_i,  // first open us
    input  slice_cnt_t count_end_i,    // first closed us
    output logic       slice_en_o
);

    slice_cnt_t count_q;
    slice_cnt_t count_inc;
    logic       count_last;

    assign count_inc  = count_q + SLICE_W'(1);
    // ">=" also catches a total shrunk below the running count
    assign count_last = (count_inc >= count_total_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clr_i || tsf_loaded_i) begin
            count_q <= '0;
        end else if (tsf_pulse_1m_i) begin
            count_q <= count_last ? '0 : count_inc; // wrap at total-1
        end
    end

    // window [start, end) within the period
    assign slice_en_o = (count_total_i != '0)
                     && (count_q >= count_start_i)
                     && (count_q < count_end_i);

endmodule

// File: tsf/tsf_timer.sv
// microsecond TSF counter that assumes clk_i runs at exactly CLKS_PER_US MHz and never wraps in practice
`timescale 1ns/1ns

module tsf_timer import xpu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic tsf_load_i,      // one-cycle load strobe
    input  tsf_t tsf_load_val_i,
    output tsf_t tsf_runtime_val_o,
    output logic tsf_pulse_1m_o,  // high with each new value
    output logic tsf_loaded_o     // high with a freshly loaded value
);

    logic [PRESC_W-1:0] presc_q;
    logic               presc_wrap;

    assign presc_wrap = (presc_q == PRESC_W'(CLKS_PER_US - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            presc_q           <= '0;
            tsf_runtime_val_o <= '0;
            tsf_pulse_1m_o    <= 1'b0;
            tsf_loaded_o      <= 1'b0;
        end else begin
            tsf_loaded_o <= tsf_load_i;
            if (tsf_load_i) begin
                // load wins over a pending step, us phase restarts
                presc_q           <= '0;
                tsf_runtime_val_o <= tsf_load_val_i;
                tsf_pulse_1m_o    <= 1'b0;
            end else if (presc_wrap) begin
                presc_q           <= '0;
                tsf_runtime_val_o <= tsf_runtime_val_o + TSF_W'(1); // one us elapsed
                tsf_pulse_1m_o    <= 1'b1;
            end else begin
                presc_q        <= presc_q + PRESC_W'(1);
                tsf_pulse_1m_o <= 1'b0;
            end
        end
    end

endmodule

// File: src/xpu_ctrl_regs.sv
// write-only register bank without readback; writes to unmapped addresses are dropped
`timescale 1ns/1ns

module xpu_ctrl_regs import xpu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  reg_wr_en_i,
    input  logic [REG_ADDR_W-1:0] reg_addr_i,
    input  logic [REG_DATA_W-1:0] reg_wdata_i,
    input  logic                  slice_en0_i,
    input  logic                  slice_en1_i,
    input  logic                  tx_rf_is_ongoing_i,
    output logic                  tsf_load_o,
    output tsf_t                  tsf_load_val_o,
    output slice_cnt_t            slice0_total_o,
    output slice_cnt_t            slice0_start_o,
    output slice_cnt_t            slice0_end_o,
    output slice_cnt_t            slice1_total_o,
    output slice_cnt_t            slice1_start_o,
    output slice_cnt_t            slice1_end_o,
    output logic [DELAY_W-1:0]    rf_delay_o,
    output logic                  txdet_clr_o,
    output logic                  slice_clr_o,
    output logic                  mute_adc_o,
    output logic                  high_tx_allowed0_o,
    output logic                  high_tx_allowed1_o
);

    logic [REG_DATA_W-1:0] tsf_lo_q, tsf_hi_q;
    logic mute_en_q, mute_val_q, hta0_en_q, hta0_val_q, hta1_en_q, hta1_val_q;
    logic hi_wr;

    assign hi_wr = reg_wr_en_i && (reg_addr_i == ADDR_TSF_HI);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tsf_lo_q <= '0;
            tsf_hi_q <= '0;
            {mute_en_q, mute_val_q, hta0_en_q, hta0_val_q, hta1_en_q, hta1_val_q} <= '0;
            {txdet_clr_o, slice_clr_o} <= '0;
            rf_delay_o <= '0;
            {slice0_total_o, slice0_start_o, slice0_end_o} <= '0;
            {slice1_total_o, slice1_start_o, slice1_end_o} <= '0;
            tsf_load_o <= 1'b0;
        end else begin
            // load only on a 0 -> 1 change of the msb
            tsf_load_o <= hi_wr && reg_wdata_i[TSF_LOAD_BIT] && !tsf_hi_q[TSF_LOAD_BIT];
            if (reg_wr_en_i) begin
                case (reg_addr_i)
                    ADDR_SOFT_RST: begin
                        txdet_clr_o <= reg_wdata_i[RST_TXDET];
                        slice_clr_o <= reg_wdata_i[RST_SLICE];
                    end
                    ADDR_OVERRIDE: begin
                        mute_en_q  <= reg_wdata_i[OVR_MUTE_EN];
                        mute_val_q <= reg_wdata_i[OVR_MUTE_VAL];
                        hta0_en_q  <= reg_wdata_i[OVR_HTA0_EN];
                        hta0_val_q <= reg_wdata_i[OVR_HTA0_VAL];
                        hta1_en_q  <= reg_wdata_i[OVR_HTA1_EN];
                        hta1_val_q <= reg_wdata_i[OVR_HTA1_VAL];
                    end
                    ADDR_TSF_LO:       tsf_lo_q       <= reg_wdata_i;
                    ADDR_TSF_HI:       tsf_hi_q       <= reg_wdata_i;
                    ADDR_RF_DELAY:     rf_delay_o     <= reg_wdata_i[DELAY_W-1:0];
                    ADDR_SLICE0_TOTAL: slice0_total_o <= reg_wdata_i[SLICE_W-1:0];
                    ADDR_SLICE0_START: slice0_start_o <= reg_wdata_i[SLICE_W-1:0];
                    ADDR_SLICE0_END:   slice0_end_o   <= reg_wdata_i[SLICE_W-1:0];
                    ADDR_SLICE1_TOTAL: slice1_total_o <= reg_wdata_i[SLICE_W-1:0];
                    ADDR_SLICE1_START: slice1_start_o <= reg_wdata_i[SLICE_W-1:0];
                    ADDR_SLICE1_END:   slice1_end_o   <= reg_wdata_i[SLICE_W-1:0];
                    default: ; // unmapped
                endcase
            end
        end
    end

    // msb of the high word is the load trigger, never part of the value
    assign tsf_load_val_o = {1'b0, tsf_hi_q[REG_DATA_W-2:0], tsf_lo_q};

    // software overrides
    assign mute_adc_o         = mute_en_q ? mute_val_q : tx_rf_is_ongoing_i; // self rx mute
    assign high_tx_allowed0_o = hta0_en_q ? hta0_val_q : slice_en0_i;
    assign high_tx_allowed1_o = hta1_en_q ? hta1_val_q : slice_en1_i;

endmodule

// File: common/xpu_pkg.sv
// shared constants for the lower-MAC time base; the core clock must run at CLKS_PER_US MHz
package xpu_pkg;

    // core clock cycles in one TSF microsecond
    localparam int CLKS_PER_US = 125;
    localparam int PRESC_W     = $clog2(CLKS_PER_US); // prescaler width

    // register write port
    localparam int REG_ADDR_W = 5;
    localparam int REG_DATA_W = 32;

    // 802.11 TSF timer width
    localparam int TSF_W = 64;
    typedef logic [TSF_W-1:0] tsf_t;

    localparam int SLICE_W = 20; // slice counts in microseconds
    typedef logic [SLICE_W-1:0] slice_cnt_t;

    localparam int DELAY_W = 14; // rf tail in clock cycles

    // register map
    localparam logic [REG_ADDR_W-1:0] ADDR_SOFT_RST     = 5'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_OVERRIDE     = 5'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_TSF_LO       = 5'd2;
    localparam logic [REG_ADDR_W-1:0] ADDR_TSF_HI       = 5'd3;  // msb rising edge loads
    localparam logic [REG_ADDR_W-1:0] ADDR_RF_DELAY     = 5'd10;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE0_TOTAL = 5'd20;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE0_START = 5'd21;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE0_END   = 5'd22;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE1_TOTAL = 5'd23;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE1_START = 5'd24;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLICE1_END   = 5'd25;

    // bit positions inside the words
    localparam int TSF_LOAD_BIT = 31;
    localparam int OVR_MUTE_EN  = 0;
    localparam int OVR_MUTE_VAL = 31;
    localparam int OVR_HTA0_EN  = 4;
    localparam int OVR_HTA0_VAL = 1;
    localparam int OVR_HTA1_EN  = 12;
    localparam int OVR_HTA1_VAL = 8;
    localparam int RST_TXDET    = 0;  // soft clear of tx detection
    localparam int RST_SLICE    = 7;  // soft clear of both slices

endpackage
